//--- Bender.yml
package:
  name: uart_axi

sources:
  - hw/uart_pkg.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/uart_regs.sv
  - hw/uart_axi_slave.sv
  - hw/uart_axi.sv
  - target: test
    files:
      - verif/tb_uart_axi.sv

//--- hw/uart_axi.sv
module uart_axi #(
    parameter uart_pkg::uart_div_t DEFAULT_DIVISOR = 16
) (
    input  logic                clock,
    input  logic                reset,

    input  logic                arvalid,
    output logic                arready,
    input  uart_pkg::axi_addr_t araddr,
    input  uart_pkg::axi_len_t  arlen,
    input  logic [2:0]          arsize,
    input  logic [1:0]          arburst,
    input  uart_pkg::axi_id_t   arid,
    output logic                rvalid,
    input  logic                rready,
    output uart_pkg::axi_data_t rdata,
    output uart_pkg::axi_resp_t rresp,
    output uart_pkg::axi_id_t   rid,
    output logic                rlast,

    input  logic                awvalid,
    output logic                awready,
    input  uart_pkg::axi_addr_t awaddr,
    input  uart_pkg::axi_id_t   awid,
    input  uart_pkg::axi_len_t  awlen,
    input  logic [2:0]          awsize,
    input  logic [1:0]          awburst,
    input  logic                wvalid,
    output logic                wready,
    input  uart_pkg::axi_data_t wdata,
    input  logic [3:0]          wstrb,
    input  logic                wlast,
    output logic                bvalid,
    input  logic                bready,
    output uart_pkg::axi_resp_t bresp,
    output uart_pkg::axi_id_t   bid,

    output logic                txd,
    input  logic                rxd                 // Asynchronous
);

    // Register strobes
    logic                  reg_write, reg_read, reg_error;
    uart_pkg::reg_offset_t reg_offset;
    uart_pkg::axi_data_t   reg_wdata, reg_rdata;

    // Serial side
    logic                  tx_start, tx_busy, rx_strobe, rx_frame_error;
    uart_pkg::uart_byte_t  tx_data, rx_data;
    uart_pkg::uart_div_t   divisor;

    uart_axi_slave u_axi (.*);

    uart_regs #(.DEFAULT_DIVISOR(DEFAULT_DIVISOR)) u_regs (
        .clock(clock), .reset(reset),
        .reg_write(reg_write), .reg_read(reg_read), .reg_offset(reg_offset),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .reg_error(reg_error),
        .tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy), .divisor(divisor),
        .rx_strobe(rx_strobe), .rx_data(rx_data), .rx_frame_error(rx_frame_error)
    );

    uart_tx u_tx (
        .clock(clock), .reset(reset), .divisor(divisor),
        .tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy), .txd(txd)
    );

    uart_rx u_rx (
        .clock(clock), .reset(reset), .divisor(divisor), .rxd(rxd),
        .rx_strobe(rx_strobe), .rx_data(rx_data), .rx_frame_error(rx_frame_error)
    );

endmodule

//--- hw/uart_axi_slave.sv
module uart_axi_slave (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  arvalid,
    output logic                  arready,
    input  uart_pkg::axi_addr_t   araddr,
    input  uart_pkg::axi_len_t    arlen,
    input  logic [2:0]            arsize,       // Sizes, bursts and strobes ignored
    input  logic [1:0]            arburst,
    input  uart_pkg::axi_id_t     arid,
    output logic                  rvalid,
    input  logic                  rready,
    output uart_pkg::axi_data_t   rdata,
    output uart_pkg::axi_resp_t   rresp,
    output uart_pkg::axi_id_t     rid,
    output logic                  rlast,

    input  logic                  awvalid,
    output logic                  awready,
    input  uart_pkg::axi_addr_t   awaddr,
    input  uart_pkg::axi_id_t     awid,
    input  uart_pkg::axi_len_t    awlen,
    input  logic [2:0]            awsize,
    input  logic [1:0]            awburst,
    input  logic                  wvalid,
    output logic                  wready,
    input  uart_pkg::axi_data_t   wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wlast,
    output logic                  bvalid,
    input  logic                  bready,
    output uart_pkg::axi_resp_t   bresp,
    output uart_pkg::axi_id_t     bid,

    output logic                  reg_write,
    output logic                  reg_read,
    output uart_pkg::reg_offset_t reg_offset,
    output uart_pkg::axi_data_t   reg_wdata,
    input  uart_pkg::axi_data_t   reg_rdata,
    input  logic                  reg_error
);

    logic                  ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic                  aw_held, w_held;
    logic                  aw_have, w_have;
    logic                  wr_done, wr_bad;
    uart_pkg::reg_offset_t aw_offset_q, wr_offset;
    uart_pkg::axi_id_t     awid_q, wr_id;
    uart_pkg::axi_len_t    awlen_q, wr_len;
    uart_pkg::axi_data_t   wdata_q, wr_data;
    logic                  wlast_q, wr_last;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    assign arready = !rvalid;                       // One read in flight
    assign awready = !bvalid && !aw_held;
    assign wready  = !bvalid && !w_held;
    assign rlast   = rvalid;                        // Always a single beat

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobe generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign aw_have   = aw_held || aw_fire;
    assign w_have    = w_held || w_fire;
    assign wr_offset = aw_held ? aw_offset_q : awaddr[3:2];
    assign wr_id     = aw_held ? awid_q : awid;
    assign wr_len    = aw_held ? awlen_q : awlen;
    assign wr_data   = w_held ? wdata_q : wdata;
    assign wr_last   = w_held ? wlast_q : wlast;

    assign reg_read  = ar_fire && (arlen == '0);
    assign wr_done   = aw_have && w_have && !bvalid && !reg_read;  // Read wins a tie
    assign wr_bad    = (wr_len != '0) || !wr_last;
    assign reg_write = wr_done && !wr_bad;
    assign reg_offset = reg_read ? araddr[3:2] : wr_offset;
    assign reg_wdata  = wr_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            if (ar_fire) rvalid <= 1'b1;
            else if (r_fire) rvalid <= 1'b0;
            if (wr_done) bvalid <= 1'b1;
            else if (b_fire) bvalid <= 1'b0;
            if (wr_done) aw_held <= 1'b0;
            else if (aw_fire) aw_held <= 1'b1;      // Stalled behind a read
            if (wr_done) w_held <= 1'b0;
            else if (w_fire) w_held <= 1'b1;
        end
    end

    // Response and request payload
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            rid   <= arid;
            rdata <= reg_read ? reg_rdata : '0;
            rresp <= (reg_read && !reg_error) ? uart_pkg::RESP_OKAY : uart_pkg::RESP_SLVERR;
        end
        if (aw_fire) begin
            aw_offset_q <= awaddr[3:2];
            awid_q      <= awid;
            awlen_q     <= awlen;
        end
        if (w_fire) begin
            wdata_q <= wdata;
            wlast_q <= wlast;
        end
        if (wr_done) begin
            bid   <= wr_id;
            bresp <= (reg_write && !reg_error) ? uart_pkg::RESP_OKAY : uart_pkg::RESP_SLVERR;
        end
    end

    a_r_hold: assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid))
        else $error("R channel dropped before rready");
    a_b_hold: assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp) && $stable(bid))
        else $error("B channel dropped before bready");
    a_one_strobe: assert property (@(posedge clock) disable iff (reset)
        !(reg_write && reg_read))
        else $error("Register read and write in one cycle");

endmodule

//--- hw/uart_pkg.sv
package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI field widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;                 // Beats minus one
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [1:0] reg_offset_t;               // Address bits 3:2

    localparam reg_offset_t OFF_TXDATA  = 2'd0;     // 0x0
    localparam reg_offset_t OFF_RXDATA  = 2'd1;     // 0x4
    localparam reg_offset_t OFF_STATUS  = 2'd2;     // 0x8
    localparam reg_offset_t OFF_DIVISOR = 2'd3;     // 0xC

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0]  uart_byte_t;
    typedef logic [15:0] uart_div_t;                // Clocks per bit

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,                                   // Half period to mid start bit
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

//--- hw/uart_regs.sv
module uart_regs #(
    parameter uart_pkg::uart_div_t DEFAULT_DIVISOR = 16
) (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  reg_write,
    input  logic                  reg_read,
    input  uart_pkg::reg_offset_t reg_offset,
    input  uart_pkg::axi_data_t   reg_wdata,
    output uart_pkg::axi_data_t   reg_rdata,
    output logic                  reg_error,

    output logic                  tx_start,
    output uart_pkg::uart_byte_t  tx_data,
    input  logic                  tx_busy,
    output uart_pkg::uart_div_t   divisor,

    input  logic                  rx_strobe,
    input  uart_pkg::uart_byte_t  rx_data,
    input  logic                  rx_frame_error
);

    logic                 rx_valid;
    logic                 rx_overrun;
    logic                 rx_frame_err;
    uart_pkg::uart_byte_t rx_byte;
    logic                 rx_read, status_read, overrun_set;

    assign rx_read     = reg_read && (reg_offset == uart_pkg::OFF_RXDATA);
    assign status_read = reg_read && (reg_offset == uart_pkg::OFF_STATUS);
    assign overrun_set = rx_strobe && rx_valid && !rx_read;   // Read frees the slot

    assign tx_start = reg_write && (reg_offset == uart_pkg::OFF_TXDATA) && !tx_busy;
    assign tx_data  = reg_wdata[7:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            divisor      <= DEFAULT_DIVISOR;
            rx_valid     <= 1'b0;
            rx_overrun   <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            if (reg_write && (reg_offset == uart_pkg::OFF_DIVISOR))
                divisor <= reg_wdata[15:0];
            if (rx_strobe && !overrun_set) rx_valid <= 1'b1;
            else if (rx_read) rx_valid <= 1'b0;
            rx_overrun   <= overrun_set || (rx_overrun && !status_read);   // Set beats clear
            rx_frame_err <= rx_frame_error || (rx_frame_err && !status_read);
        end
    end

    always_ff @(posedge clock) begin
        if (rx_strobe && !overrun_set) rx_byte <= rx_data;   // Held byte kept on overrun
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data and error decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        reg_rdata = '0;
        reg_error = 1'b0;
        case (reg_offset)
            uart_pkg::OFF_TXDATA: begin
                reg_error = reg_read || (reg_write && tx_busy);  // Busy write drops byte
            end
            uart_pkg::OFF_RXDATA: begin
                if (rx_valid) reg_rdata = {24'd0, rx_byte};       // Empty reads as zero
                reg_error = reg_write;
            end
            uart_pkg::OFF_STATUS: begin
                reg_rdata = {28'd0, rx_frame_err, rx_overrun, rx_valid, tx_busy};
                reg_error = reg_write;
            end
            default: begin
                reg_rdata = {16'd0, divisor};
            end
        endcase
    end

    a_tx_start: assert property (@(posedge clock) disable iff (reset)
        tx_start |-> !tx_busy ##1 tx_busy)
        else $error("Transmitter start while busy or not taken");

endmodule

//--- hw/uart_rx.sv
module uart_rx (
    input  logic                 clock,
    input  logic                 reset,
    input  uart_pkg::uart_div_t  divisor,
    input  logic                 rxd,
    output logic                 rx_strobe,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_frame_error
);

    logic                rxd_meta, rxd_sync, rxd_prev;
    logic                falling;
    uart_pkg::rx_state_t state;
    uart_pkg::uart_div_t count;
    logic [2:0]          bit_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Synchronizer and edge detect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            rxd_meta <= 1'b1;                       // Line idles high
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign falling = rxd_prev && !rxd_sync;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= uart_pkg::RX_IDLE;
            count          <= '0;
            bit_idx        <= '0;
            rx_strobe      <= 1'b0;
            rx_frame_error <= 1'b0;
        end else begin
            rx_strobe      <= 1'b0;
            rx_frame_error <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (falling) begin
                        state <= uart_pkg::RX_START;
                        count <= (divisor >> 1) - 16'd1;   // Aim at mid start bit
                    end
                end
                uart_pkg::RX_START: begin
                    if (count != '0) count <= count - 16'd1;
                    else if (rxd_sync) state <= uart_pkg::RX_IDLE;  // Glitch
                    else begin
                        state   <= uart_pkg::RX_DATA;
                        count   <= divisor - 16'd1;
                        bit_idx <= '0;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (count != '0) count <= count - 16'd1;
                    else begin
                        count   <= divisor - 16'd1;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= uart_pkg::RX_STOP;
                    end
                end
                default: begin
                    if (count != '0) count <= count - 16'd1;
                    else begin
                        state          <= uart_pkg::RX_IDLE;
                        rx_strobe      <= rxd_sync;
                        rx_frame_error <= !rxd_sync;      // Low stop bit
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == uart_pkg::RX_DATA && count == '0)
            rx_data <= {rxd_sync, rx_data[7:1]};    // LSB arrives first
    end

endmodule

//--- hw/uart_tx.sv
module uart_tx (
    input  logic                 clock,
    input  logic                 reset,
    input  uart_pkg::uart_div_t  divisor,
    input  logic                 tx_start,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx_busy,
    output logic                 txd
);

    uart_pkg::tx_state_t  state;
    uart_pkg::uart_div_t  count;                    // Clocks left in this bit
    logic [2:0]           bit_idx;
    uart_pkg::uart_byte_t shift;

    assign tx_busy = (state != uart_pkg::TX_IDLE);
    assign txd     = (state == uart_pkg::TX_START) ? 1'b0 :
                     (state == uart_pkg::TX_DATA)  ? shift[0] : 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= uart_pkg::TX_IDLE;
            count   <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (tx_start) begin
                        state <= uart_pkg::TX_START;
                        count <= divisor - 16'd1;
                    end
                end
                uart_pkg::TX_START: begin
                    if (count == '0) begin
                        state   <= uart_pkg::TX_DATA;
                        count   <= divisor - 16'd1;   // Reloaded per bit
                        bit_idx <= '0;
                    end else count <= count - 16'd1;
                end
                uart_pkg::TX_DATA: begin
                    if (count == '0) begin
                        count   <= divisor - 16'd1;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= uart_pkg::TX_STOP;
                    end else count <= count - 16'd1;
                end
                default: begin
                    if (count == '0) state <= uart_pkg::TX_IDLE;
                    else count <= count - 16'd1;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == uart_pkg::TX_IDLE && tx_start) shift <= tx_data;
        else if (state == uart_pkg::TX_DATA && count == '0) shift <= shift >> 1;  // LSB first
    end

endmodule

//--- uart_axi.f
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_axi_slave.sv
hw/uart_axi.sv
verif/tb_uart_axi.sv

//--- verif/tb_uart_axi.sv
module tb_uart_axi;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_DIV         = 12;                    // Largest divisor the tests use
    localparam int WATCHDOG_CYCLES = 6 * 10 * MAX_DIV + 2000;

    logic                  clock;
    logic                  reset;
    logic                  arvalid, arready, rvalid, rready, rlast;
    uart_pkg::axi_addr_t   araddr, awaddr;
    uart_pkg::axi_len_t    arlen, awlen;
    logic [2:0]            arsize, awsize;
    logic [1:0]            arburst, awburst;
    uart_pkg::axi_id_t     arid, rid, awid, bid;
    uart_pkg::axi_data_t   rdata, wdata;
    uart_pkg::axi_resp_t   rresp, bresp;
    logic                  awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [3:0]            wstrb;
    logic                  txd, rxd;
    logic                  loopback;                        // Ties rxd to txd
    logic                  rxd_drive;
    int                    cur_div;
    int                    checks;
    int                    errors;

    assign rxd = loopback ? txd : rxd_drive;

    uart_axi #(.DEFAULT_DIVISOR(16'd8)) u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_data(input string name, input uart_pkg::axi_data_t exp,
                              input uart_pkg::axi_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input uart_pkg::axi_resp_t exp,
                              input uart_pkg::axi_resp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_id(input string name, input uart_pkg::axi_id_t exp,
                            input uart_pkg::axi_id_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input uart_pkg::uart_byte_t exp,
                              input uart_pkg::uart_byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        checks++;
        errors++;
        $display("Failure: %s", msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic axi_read(input uart_pkg::reg_offset_t offset, input uart_pkg::axi_len_t len,
                            input uart_pkg::axi_id_t id, output uart_pkg::axi_data_t data,
                            output uart_pkg::axi_resp_t resp, output uart_pkg::axi_id_t got_id,
                            output logic last);
        @(posedge clock);
        arvalid <= 1'b1;
        araddr  <= {28'd0, offset, 2'b00};
        arlen   <= len;
        arid    <= id;
        rready  <= 1'b1;
        do @(posedge clock); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clock); while (!rvalid);               // R handshake at this edge
        data   = rdata;
        resp   = rresp;
        got_id = rid;
        last   = rlast;
        rready <= 1'b0;
    endtask

    task automatic axi_write(input uart_pkg::reg_offset_t offset, input uart_pkg::axi_len_t len,
                             input uart_pkg::axi_id_t id, input uart_pkg::axi_data_t data,
                             output uart_pkg::axi_resp_t resp, output uart_pkg::axi_id_t got_id);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clock);
        awvalid <= 1'b1;
        awaddr  <= {28'd0, offset, 2'b00};
        awlen   <= len;
        awid    <= id;
        wvalid  <= 1'b1;
        wdata   <= data;
        wlast   <= 1'b1;
        bready  <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge clock);
            if (!aw_done && awready) begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (!w_done && wready) begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
        end
        do @(posedge clock); while (!bvalid);
        resp   = bresp;
        got_id = bid;
        bready <= 1'b0;
    endtask

    task automatic read_check(input uart_pkg::reg_offset_t offset, input uart_pkg::axi_len_t len,
                              input uart_pkg::axi_data_t exp_data,
                              input uart_pkg::axi_resp_t exp_resp);
        uart_pkg::axi_id_t   id;
        uart_pkg::axi_id_t   got_id;
        uart_pkg::axi_data_t data;
        uart_pkg::axi_resp_t resp;
        logic                last;
        id = $urandom_range(15);
        axi_read(offset, len, id, data, resp, got_id, last);
        check_resp("rresp", exp_resp, resp);
        check_id("rid", id, got_id);
        if (last !== 1'b1) report_failure("rlast was not set on the read response");
        if (exp_resp == uart_pkg::RESP_OKAY) check_data("rdata", exp_data, data);
    endtask

    task automatic write_check(input uart_pkg::reg_offset_t offset,
                               input uart_pkg::axi_data_t data,
                               input uart_pkg::axi_resp_t exp_resp);
        uart_pkg::axi_id_t   id;
        uart_pkg::axi_id_t   got_id;
        uart_pkg::axi_resp_t resp;
        id = $urandom_range(15);
        axi_write(offset, 8'd0, id, data, resp, got_id);
        check_resp("bresp", exp_resp, resp);
        check_id("bid", id, got_id);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic capture_frame(output uart_pkg::uart_byte_t data, output logic start_bit,
                                 output logic stop_bit);
        do @(posedge clock); while (txd !== 1'b0);
        repeat (cur_div / 2) @(posedge clock);              // Middle of start bit
        start_bit = txd;
        for (int i = 0; i < 8; i++) begin
            repeat (cur_div) @(posedge clock);
            data[i] = txd;                                  // LSB first
        end
        repeat (cur_div) @(posedge clock);
        stop_bit = txd;
    endtask

    task automatic send_byte(input uart_pkg::uart_byte_t b, input logic read_busy,
                             input logic write_busy);
        uart_pkg::uart_byte_t seen;
        logic                 start_bit;
        logic                 stop_bit;
        fork
            capture_frame(seen, start_bit, stop_bit);
            begin
                write_check(uart_pkg::OFF_TXDATA, {24'd0, b}, uart_pkg::RESP_OKAY);
                if (read_busy)
                    read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h1, uart_pkg::RESP_OKAY);
                if (write_busy)
                    write_check(uart_pkg::OFF_TXDATA, {24'd0, ~b}, uart_pkg::RESP_SLVERR);
            end
        join
        if (start_bit !== 1'b0) report_failure("txd start bit was not low");
        check_byte("txd data", b, seen);
        if (stop_bit !== 1'b1) report_failure("txd stop bit was not high");
        repeat (cur_div) @(posedge clock);                  // Past the end of the stop bit
    endtask

    task automatic wait_rx_valid(output uart_pkg::axi_data_t status);
        uart_pkg::axi_resp_t resp;
        uart_pkg::axi_id_t   got_id;
        logic                last;
        int                  tries;
        tries = 0;
        do begin
            axi_read(uart_pkg::OFF_STATUS, 8'd0, 4'd0, status, resp, got_id, last);
            tries++;
        end while (!status[1] && tries < 50);
        if (!status[1]) report_failure("rx_valid never set after a loopback frame");
    endtask

    task automatic drive_serial_frame(input uart_pkg::uart_byte_t b, input logic stop);
        @(posedge clock);
        rxd_drive <= 1'b0;
        repeat (cur_div) @(posedge clock);
        for (int i = 0; i < 8; i++) begin
            rxd_drive <= b[i];
            repeat (cur_div) @(posedge clock);
        end
        rxd_drive <= stop;
        repeat (cur_div) @(posedge clock);
        rxd_drive <= 1'b1;
        repeat (cur_div) @(posedge clock);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_state();
        read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h0, uart_pkg::RESP_OKAY);
        read_check(uart_pkg::OFF_DIVISOR, 8'd0, 32'd8, uart_pkg::RESP_OKAY);
    endtask

    task automatic test_divisor_decode();
        write_check(uart_pkg::OFF_DIVISOR, 32'd12, uart_pkg::RESP_OKAY);
        cur_div = 12;
        read_check(uart_pkg::OFF_DIVISOR, 8'd0, 32'd12, uart_pkg::RESP_OKAY);
        read_check(uart_pkg::OFF_TXDATA, 8'd0, 32'h0, uart_pkg::RESP_SLVERR);
        write_check(uart_pkg::OFF_STATUS, $urandom, uart_pkg::RESP_SLVERR);
        read_check(uart_pkg::OFF_DIVISOR, 8'd3, 32'h0, uart_pkg::RESP_SLVERR);  // Burst refused
    endtask

    task automatic test_transmit();
        send_byte($urandom_range(255), 1'b1, 1'b0);
        read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h0, uart_pkg::RESP_OKAY);
    endtask

    task automatic test_busy_reject();
        send_byte($urandom_range(255), 1'b0, 1'b1);
        read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h0, uart_pkg::RESP_OKAY);   // No second frame
    endtask

    task automatic test_loopback_overrun();
        uart_pkg::uart_byte_t a;
        uart_pkg::uart_byte_t b;
        uart_pkg::axi_data_t  status;
        a = $urandom_range(255);
        do begin
            b = $urandom_range(255);
        end while (b == a);                                 // Distinct so an overwrite shows
        @(posedge clock);
        loopback <= 1'b1;
        send_byte(a, 1'b0, 1'b0);
        wait_rx_valid(status);
        check_data("STATUS", 32'h2, status);
        read_check(uart_pkg::OFF_RXDATA, 8'd0, {24'd0, a}, uart_pkg::RESP_OKAY);
        read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h0, uart_pkg::RESP_OKAY);
        send_byte(a, 1'b0, 1'b0);
        send_byte(b, 1'b0, 1'b0);                           // Lands on a full slot
        read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h6, uart_pkg::RESP_OKAY);
        read_check(uart_pkg::OFF_RXDATA, 8'd0, {24'd0, a}, uart_pkg::RESP_OKAY);
        read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h0, uart_pkg::RESP_OKAY);
    endtask

    task automatic test_frame_error();
        @(posedge clock);
        loopback <= 1'b0;
        drive_serial_frame($urandom_range(255), 1'b0);      // Low stop bit
        read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h8, uart_pkg::RESP_OKAY);
        read_check(uart_pkg::OFF_STATUS, 8'd0, 32'h0, uart_pkg::RESP_OKAY);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Watchdog and main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'he5e8));
        checks    = 0;
        errors    = 0;
        cur_div   = 8;
        reset     = 1'b1;
        arvalid   = 1'b0;
        araddr    = '0;
        arlen     = '0;
        arsize    = 3'd2;                                   // 4-byte beats
        arburst   = 2'b01;
        arid      = '0;
        rready    = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        awlen     = '0;
        awsize    = 3'd2;
        awburst   = 2'b01;
        awid      = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = 4'hf;
        wlast     = 1'b1;
        bready    = 1'b0;
        loopback  = 1'b0;
        rxd_drive = 1'b1;                                   // Idle line
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        test_reset_state();
        test_divisor_decode();
        test_transmit();
        test_busy_reject();
        test_loopback_overrun();
        test_frame_error();

        $display("Finished with %0d checks and %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
